//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////
   localparam int UART_DIV_W   = 16;              // bit duration divider
   localparam int UART_DATA_W  = 8;               // character
   localparam int UART_FRAME_W = UART_DATA_W + 2; // start + data + stop
   localparam int BIT_CNT_W    = 4;               // counts up to a full frame
   localparam int AXI_ADDR_W   = 5;
   localparam int AXI_DATA_W   = 32;

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////
   localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL   = 5'h00; // rw
   localparam logic [AXI_ADDR_W-1:0] ADDR_DIV    = 5'h04; // rw, cycles per bit
   localparam logic [AXI_ADDR_W-1:0] ADDR_TXDATA = 5'h08; // wo
   localparam logic [AXI_ADDR_W-1:0] ADDR_RXDATA = 5'h0C; // ro, read clears rx_ready
   localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 5'h10; // ro

   localparam int CTRL_TX_EN    = 0;
   localparam int CTRL_RX_EN    = 1;
   localparam int CTRL_SRST     = 2; // write-one pulse
   localparam int STAT_TX_READY = 0;
   localparam int STAT_RX_READY = 1;

   localparam logic [UART_DIV_W-1:0] DIV_RESET = 16'd16;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   ////////////////////////////////////////
   // engine program counters
   ////////////////////////////////////////
   localparam int TX_PC_W = 2;
   localparam logic [TX_PC_W-1:0] TX_IDLE  = 2'd0; // wait for tx_start
   localparam logic [TX_PC_W-1:0] TX_LOAD  = 2'd1; // build frame
   localparam logic [TX_PC_W-1:0] TX_SHIFT = 2'd2; // shift out

   localparam int RX_PC_W = 3;
   localparam logic [RX_PC_W-1:0] RX_SYNC  = 3'd0; // wait for high line
   localparam logic [RX_PC_W-1:0] RX_QUAL  = 3'd1; // idle for a full bit
   localparam logic [RX_PC_W-1:0] RX_WAIT  = 3'd2; // wait for start edge
   localparam logic [RX_PC_W-1:0] RX_START = 3'd3; // half-bit confirm
   localparam logic [RX_PC_W-1:0] RX_DATA  = 3'd4; // mid-bit sampling

endpackage

`default_nettype wire

//--- verilog/uart_ctrl_if.sv
`default_nettype none

interface uart_ctrl_if;

   logic                             tx_en;        // ctrl bit 0
   logic                             rx_en;        // ctrl bit 1
   logic [uart_pkg::UART_DATA_W-1:0] tx_data;      // byte to send
   logic                             tx_start;     // one-cycle launch
   logic [uart_pkg::UART_DIV_W-1:0]  bit_duration; // cycles per bit
   logic                             tx_ready;     // tx idle and enabled
   logic [uart_pkg::UART_DATA_W-1:0] rx_data;      // last received byte
   logic                             rx_ready;     // unread byte held
   logic                             rx_read;      // one-cycle, clears rx_ready

   modport regs (
      output tx_en, rx_en, tx_data, tx_start, bit_duration, rx_read,
      input  tx_ready, rx_data, rx_ready
   );

   modport tx (
      input  tx_en, tx_data, tx_start, bit_duration,
      output tx_ready
   );

   modport rx (
      input  rx_en, bit_duration, rx_read,
      output rx_data, rx_ready
   );

endinterface

`default_nettype wire

//--- verilog/uart_regs.sv
`default_nettype none

module uart_regs (
   input  wire                                clk,
   input  wire                                rst_int,
   input  wire [uart_pkg::AXI_ADDR_W-1:0]     s_awaddr,
   input  wire                                s_awvalid,
   output logic                               s_awready,
   input  wire [uart_pkg::AXI_DATA_W-1:0]     s_wdata,
   input  wire [uart_pkg::AXI_DATA_W/8-1:0]   s_wstrb,
   input  wire                                s_wvalid,
   output logic                               s_wready,
   output logic [1:0]                         s_bresp,
   output logic                               s_bvalid,
   input  wire                                s_bready,
   input  wire [uart_pkg::AXI_ADDR_W-1:0]     s_araddr,
   input  wire                                s_arvalid,
   output logic                               s_arready,
   output logic [uart_pkg::AXI_DATA_W-1:0]    s_rdata,
   output logic [1:0]                         s_rresp,
   output logic                               s_rvalid,
   input  wire                                s_rready,
   uart_ctrl_if.regs                          ctrl,
   output logic                               soft_rst
);

   logic                            wr_req;  // aw+w present, nothing pending
   logic                            rd_req;  // ar present, nothing pending
   logic                            wr_err;
   logic                            rd_err;
   logic                            tx_go;   // accepted txdata write
   logic [uart_pkg::AXI_DATA_W-1:0] rd_word;

   assign wr_req   = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
   assign rd_req   = s_arvalid && !s_arready && !s_rvalid;
   assign tx_go    = wr_req && (s_awaddr == uart_pkg::ADDR_TXDATA) && ctrl.tx_ready;
   assign s_wready = s_awready; // aw and w always taken together

   ////////////////////////////////////////
   // write decode
   ////////////////////////////////////////
   always_comb begin
      case (s_awaddr)
         uart_pkg::ADDR_CTRL,
         uart_pkg::ADDR_DIV:    wr_err = 1'b0;
         uart_pkg::ADDR_TXDATA: wr_err = !ctrl.tx_ready; // busy, byte dropped
         default:               wr_err = 1'b1;           // ro or unmapped
      endcase
   end

   ////////////////////////////////////////
   // read mux
   ////////////////////////////////////////
   always_comb begin
      rd_word = '0;
      rd_err  = 1'b0;
      case (s_araddr)
         uart_pkg::ADDR_CTRL: begin
            rd_word[uart_pkg::CTRL_TX_EN] = ctrl.tx_en;
            rd_word[uart_pkg::CTRL_RX_EN] = ctrl.rx_en; // srst reads 0
         end
         uart_pkg::ADDR_DIV:    rd_word[uart_pkg::UART_DIV_W-1:0] = ctrl.bit_duration;
         uart_pkg::ADDR_RXDATA: rd_word[uart_pkg::UART_DATA_W-1:0] = ctrl.rx_data;
         uart_pkg::ADDR_STATUS: begin
            rd_word[uart_pkg::STAT_TX_READY] = ctrl.tx_ready;
            rd_word[uart_pkg::STAT_RX_READY] = ctrl.rx_ready;
         end
         default: rd_err = 1'b1; // txdata is write only
      endcase
   end

   ////////////////////////////////////////
   // handshakes, control regs, pulses
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         s_awready         <= 1'b0;
         s_bvalid          <= 1'b0;
         s_arready         <= 1'b0;
         s_rvalid          <= 1'b0;
         ctrl.tx_en        <= 1'b0;
         ctrl.rx_en        <= 1'b0;
         ctrl.bit_duration <= uart_pkg::DIV_RESET;
         ctrl.tx_start     <= 1'b0;
         ctrl.rx_read      <= 1'b0;
         soft_rst          <= 1'b0;
      end else begin
         s_awready <= wr_req; // one-cycle pulse
         s_arready <= rd_req;

         if (s_bvalid && s_bready) s_bvalid <= 1'b0;
         if (s_awready)            s_bvalid <= 1'b1; // response the cycle after
         if (s_rvalid && s_rready) s_rvalid <= 1'b0;
         if (s_arready)            s_rvalid <= 1'b1;

         ctrl.tx_start <= tx_go;
         ctrl.rx_read  <= rd_req && (s_araddr == uart_pkg::ADDR_RXDATA);
         soft_rst      <= wr_req && (s_awaddr == uart_pkg::ADDR_CTRL) && s_wstrb[0]
                          && s_wdata[uart_pkg::CTRL_SRST];

         if (wr_req && (s_awaddr == uart_pkg::ADDR_CTRL) && s_wstrb[0]) begin
            ctrl.tx_en <= s_wdata[uart_pkg::CTRL_TX_EN];
            ctrl.rx_en <= s_wdata[uart_pkg::CTRL_RX_EN];
         end
         if (wr_req && (s_awaddr == uart_pkg::ADDR_DIV)) begin
            if (s_wstrb[0]) ctrl.bit_duration[7:0] <= s_wdata[7:0]; // per byte lane
            if (s_wstrb[1]) begin
               ctrl.bit_duration[uart_pkg::UART_DIV_W-1:8] <=
                  s_wdata[uart_pkg::UART_DIV_W-1:8];
            end
         end
      end
   end

   // responses and data words, held until the handshake
   always_ff @(posedge clk) begin
      if (wr_req) begin
         s_bresp <= wr_err ? uart_pkg::RESP_SLVERR : uart_pkg::RESP_OKAY;
      end
      if (tx_go) begin
         ctrl.tx_data <= s_wdata[uart_pkg::UART_DATA_W-1:0];
      end
      if (rd_req) begin
         s_rdata <= rd_word;
         s_rresp <= rd_err ? uart_pkg::RESP_SLVERR : uart_pkg::RESP_OKAY;
      end
   end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`default_nettype none

module uart_tx (
   input  wire     clk,
   input  wire     rst_int, // hard or soft
   input  wire     cts,
   output logic    txd,
   uart_ctrl_if.tx ctrl
);

   logic [1:0]                        cts_sync;  // 2-flop synchronizer
   logic                              run;       // enabled and clear to send
   logic [uart_pkg::TX_PC_W-1:0]      pc;
   logic [uart_pkg::UART_FRAME_W-1:0] pattern;   // {stop, data, start}
   logic [uart_pkg::BIT_CNT_W-1:0]    bit_cnt;
   logic [uart_pkg::UART_DIV_W-1:0]   cycle_cnt;

   assign run = ctrl.tx_en && cts_sync[1];
   assign txd = pattern[0]; // lsb goes out first

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) cts_sync <= 2'b00;
      else         cts_sync <= {cts_sync[0], cts};
   end

   ////////////////////////////////////////
   // transmit sequencer
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         pc            <= uart_pkg::TX_IDLE;
         ctrl.tx_ready <= 1'b0;
         pattern       <= '1; // line idles high
         bit_cnt       <= '0;
         cycle_cnt     <= '0;
      end else if (!run) begin
         pc            <= uart_pkg::TX_IDLE; // abort frame
         ctrl.tx_ready <= 1'b0;
         pattern       <= '1;
         bit_cnt       <= '0;
         cycle_cnt     <= '0;
      end else begin
         case (pc)
            uart_pkg::TX_IDLE: begin
               ctrl.tx_ready <= !ctrl.tx_start;
               pattern       <= '1;
               bit_cnt       <= '0;
               cycle_cnt     <= 1;
               if (ctrl.tx_start) pc <= uart_pkg::TX_LOAD;
            end
            uart_pkg::TX_LOAD: begin
               pattern <= {1'b1, ctrl.tx_data, 1'b0}; // start bit on txd next
               pc      <= uart_pkg::TX_SHIFT;
            end
            uart_pkg::TX_SHIFT: begin
               cycle_cnt <= cycle_cnt + 1'b1;
               if (cycle_cnt == ctrl.bit_duration) begin // bit time done
                  if (bit_cnt == uart_pkg::BIT_CNT_W'(uart_pkg::UART_FRAME_W - 1)) begin
                     pc <= uart_pkg::TX_IDLE; // stop bit sent
                  end else begin
                     pattern   <= pattern >> 1;
                     bit_cnt   <= bit_cnt + 1'b1;
                     cycle_cnt <= 1;
                  end
               end
            end
            default: pc <= uart_pkg::TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
`default_nettype none

module uart_rx (
   input  wire     clk,
   input  wire     rst_int, // hard or soft
   input  wire     rxd,
   output logic    rts,
   uart_ctrl_if.rx ctrl
);

   logic [1:0]                       rxd_sync;  // line synchronizer
   logic                             line;
   logic                             sample;    // mid-bit sample point
   logic                             stop_bit;  // sample lands on stop bit
   logic [uart_pkg::RX_PC_W-1:0]     pc;
   logic [uart_pkg::UART_DIV_W-1:0]  cycle_cnt;
   logic [uart_pkg::BIT_CNT_W-1:0]   bit_cnt;
   logic [uart_pkg::UART_DATA_W-1:0] shift_q;   // lsb first

   assign line     = rxd_sync[1];
   assign sample   = ctrl.rx_en && (pc == uart_pkg::RX_DATA)
                     && (cycle_cnt == ctrl.bit_duration);
   assign stop_bit = (bit_cnt == uart_pkg::BIT_CNT_W'(uart_pkg::UART_DATA_W));

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) rxd_sync <= 2'b11;
      else         rxd_sync <= {rxd_sync[0], rxd};
   end

   ////////////////////////////////////////
   // receive program
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         pc            <= uart_pkg::RX_SYNC;
         cycle_cnt     <= 1;
         bit_cnt       <= '0;
         ctrl.rx_ready <= 1'b0;
         rts           <= 1'b0;
      end else if (!ctrl.rx_en) begin
         pc            <= uart_pkg::RX_SYNC;
         cycle_cnt     <= 1;
         bit_cnt       <= '0;
         ctrl.rx_ready <= 1'b0;
         rts           <= 1'b0;
      end else begin
         rts <= 1'b1;
         if (ctrl.rx_read) ctrl.rx_ready <= 1'b0; // a new byte below wins
         case (pc)
            uart_pkg::RX_SYNC: begin
               cycle_cnt <= 1;
               bit_cnt   <= '0;
               if (line) pc <= uart_pkg::RX_QUAL;
            end
            uart_pkg::RX_QUAL: begin
               cycle_cnt <= cycle_cnt + 1'b1;
               if (!line) pc <= uart_pkg::RX_SYNC; // dropped early
               else if (cycle_cnt == ctrl.bit_duration) pc <= uart_pkg::RX_WAIT;
            end
            uart_pkg::RX_WAIT: begin
               cycle_cnt <= 1;
               if (!line) pc <= uart_pkg::RX_START; // falling edge
            end
            uart_pkg::RX_START: begin
               cycle_cnt <= cycle_cnt + 1'b1;
               if (cycle_cnt == (ctrl.bit_duration >> 1)) begin // half bit
                  if (line) begin
                     pc <= uart_pkg::RX_SYNC; // glitch, resync
                  end else begin
                     cycle_cnt <= 1;
                     bit_cnt   <= '0;
                     pc        <= uart_pkg::RX_DATA;
                  end
               end
            end
            uart_pkg::RX_DATA: begin
               cycle_cnt <= cycle_cnt + 1'b1;
               if (sample) begin
                  cycle_cnt <= 1;
                  bit_cnt   <= bit_cnt + 1'b1;
                  if (stop_bit) begin
                     bit_cnt <= '0;
                     pc      <= uart_pkg::RX_WAIT;
                     if (line) ctrl.rx_ready <= 1'b1; // good stop only, else dropped
                  end
               end
            end
            default: pc <= uart_pkg::RX_SYNC;
         endcase
      end
   end

   // data path
   always_ff @(posedge clk) begin
      if (sample && !stop_bit) shift_q <= {line, shift_q[uart_pkg::UART_DATA_W-1:1]};
      if (sample && stop_bit && line) ctrl.rx_data <= shift_q; // overwrites unread byte
   end

endmodule

`default_nettype wire

//--- verilog/uart_top.sv
`default_nettype none

module uart_top (
   input  wire                               clk,
   input  wire                               rst_int,
   input  wire [uart_pkg::AXI_ADDR_W-1:0]    s_awaddr,
   input  wire                               s_awvalid,
   output logic                              s_awready,
   input  wire [uart_pkg::AXI_DATA_W-1:0]    s_wdata,
   input  wire [uart_pkg::AXI_DATA_W/8-1:0]  s_wstrb,
   input  wire                               s_wvalid,
   output logic                              s_wready,
   output logic [1:0]                        s_bresp,
   output logic                              s_bvalid,
   input  wire                               s_bready,
   input  wire [uart_pkg::AXI_ADDR_W-1:0]    s_araddr,
   input  wire                               s_arvalid,
   output logic                              s_arready,
   output logic [uart_pkg::AXI_DATA_W-1:0]   s_rdata,
   output logic [1:0]                        s_rresp,
   output logic                              s_rvalid,
   input  wire                               s_rready,
   output logic                              txd,
   input  wire                               rxd,
   input  wire                               cts,
   output logic                              rts
);

   logic soft_rst; // pulse from ctrl write
   logic eng_rst;  // engines only, regs keep state

   uart_ctrl_if ctrl_bus ();

   assign eng_rst = rst_int | soft_rst;

   uart_regs u_regs (
      .clk       (clk),
      .rst_int   (rst_int),
      .s_awaddr  (s_awaddr),
      .s_awvalid (s_awvalid),
      .s_awready (s_awready),
      .s_wdata   (s_wdata),
      .s_wstrb   (s_wstrb),
      .s_wvalid  (s_wvalid),
      .s_wready  (s_wready),
      .s_bresp   (s_bresp),
      .s_bvalid  (s_bvalid),
      .s_bready  (s_bready),
      .s_araddr  (s_araddr),
      .s_arvalid (s_arvalid),
      .s_arready (s_arready),
      .s_rdata   (s_rdata),
      .s_rresp   (s_rresp),
      .s_rvalid  (s_rvalid),
      .s_rready  (s_rready),
      .ctrl      (ctrl_bus.regs),
      .soft_rst  (soft_rst)
   );

   uart_tx u_tx (
      .clk     (clk),
      .rst_int (eng_rst),
      .cts     (cts),
      .txd     (txd),
      .ctrl    (ctrl_bus.tx)
   );

   uart_rx u_rx (
      .clk     (clk),
      .rst_int (eng_rst),
      .rxd     (rxd),
      .rts     (rts),
      .ctrl    (ctrl_bus.rx)
   );

endmodule

`default_nettype wire

//--- dv/uart_tb.sv
`default_nettype none

module uart_tb;

   localparam int HALF_PERIOD = 20;  // 40 unit clock
   localparam int DRIVE_DLY   = 2;   // inputs change after the edge
   localparam int HS_LIMIT    = 50;  // cycles per handshake
   localparam int POLL_LIMIT  = 100; // status reads per poll
   localparam int LOOP_DIV    = 8;   // bit time used for traffic
   localparam int NUM_BYTES   = 8;

   logic        clk;
   logic        rst_int;
   logic [4:0]  s_awaddr;
   logic        s_awvalid;
   logic        s_awready;
   logic [31:0] s_wdata;
   logic [3:0]  s_wstrb;
   logic        s_wvalid;
   logic        s_wready;
   logic [1:0]  s_bresp;
   logic        s_bvalid;
   logic        s_bready;
   logic [4:0]  s_araddr;
   logic        s_arvalid;
   logic        s_arready;
   logic [31:0] s_rdata;
   logic [1:0]  s_rresp;
   logic        s_rvalid;
   logic        s_rready;
   logic        txd;
   logic        cts;
   logic        rts;
   integer      seed;

   uart_top u_dut (
      .clk       (clk),
      .rst_int   (rst_int),
      .s_awaddr  (s_awaddr),
      .s_awvalid (s_awvalid),
      .s_awready (s_awready),
      .s_wdata   (s_wdata),
      .s_wstrb   (s_wstrb),
      .s_wvalid  (s_wvalid),
      .s_wready  (s_wready),
      .s_bresp   (s_bresp),
      .s_bvalid  (s_bvalid),
      .s_bready  (s_bready),
      .s_araddr  (s_araddr),
      .s_arvalid (s_arvalid),
      .s_arready (s_arready),
      .s_rdata   (s_rdata),
      .s_rresp   (s_rresp),
      .s_rvalid  (s_rvalid),
      .s_rready  (s_rready),
      .txd       (txd),
      .rxd       (txd), // serial loopback
      .cts       (cts),
      .rts       (rts)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic stop_run();
      $display("Test failures found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic timeout_stop(input string what);
      $display("timeout while waiting for %s", what);
      stop_run();
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY; // outputs settled, safe to drive and sample
   endtask

   task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      s_awaddr  = addr;
      s_wdata   = data;
      s_wstrb   = 4'hf;
      s_awvalid = 1'b1;
      s_wvalid  = 1'b1;
      s_bready  = 1'b1;
      n = 0;
      do begin
         next_cycle();
         n++;
      end while (!s_awready && !s_wready && n < HS_LIMIT);
      if (!s_awready && !s_wready) timeout_stop("awready and wready");
      check_eq("awready", {31'd0, s_awready}, 32'd1);
      check_eq("wready", {31'd0, s_wready}, 32'd1); // pulses with awready
      next_cycle(); // aw and w handshake on this edge
      s_awvalid = 1'b0;
      s_wvalid  = 1'b0;
      n = 0;
      while (!s_bvalid && n < HS_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!s_bvalid) timeout_stop("bvalid");
      resp = s_bresp;
      next_cycle(); // b handshake on this edge
      s_bready = 1'b0;
   endtask

   task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int n;
      s_araddr  = addr;
      s_arvalid = 1'b1;
      s_rready  = 1'b1;
      n = 0;
      do begin
         next_cycle();
         n++;
      end while (!s_arready && n < HS_LIMIT);
      if (!s_arready) timeout_stop("arready");
      next_cycle(); // ar handshake on this edge
      s_arvalid = 1'b0;
      n = 0;
      while (!s_rvalid && n < HS_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!s_rvalid) timeout_stop("rvalid");
      data = s_rdata;
      resp = s_rresp;
      next_cycle();
      s_rready = 1'b0;
   endtask

   // poll status until one bit reaches the wanted level
   task automatic wait_status(input int bit_idx, input logic val, input string what);
      logic [31:0] d;
      logic [1:0]  r;
      int          n;
      n = 0;
      axi_read(uart_pkg::ADDR_STATUS, d, r);
      while (d[bit_idx] !== val && n < POLL_LIMIT) begin
         axi_read(uart_pkg::ADDR_STATUS, d, r);
         n++;
      end
      if (d[bit_idx] !== val) timeout_stop(what);
   endtask

   // serial monitor, samples each bit at its middle
   task automatic frame_check(input logic [7:0] exp_byte);
      logic [9:0] frame;
      int         n;
      int         k;
      frame = {1'b1, exp_byte, 1'b0}; // stop, data, start
      n = 0;
      while (txd !== 1'b0 && n < HS_LIMIT) begin
         next_cycle();
         n++;
      end
      if (txd !== 1'b0) timeout_stop("start bit on txd");
      repeat (LOOP_DIV / 2) next_cycle(); // move to mid-bit
      for (k = 0; k < 10; k++) begin
         check_eq($sformatf("txd bit %0d", k), {31'd0, txd}, {31'd0, frame[k]});
         if (k < 9) repeat (LOOP_DIV) next_cycle();
      end
   endtask

   task automatic send_and_check(input logic [7:0] b);
      logic [31:0] d;
      logic [1:0]  r;
      logic [1:0]  wr;
      wait_status(uart_pkg::STAT_TX_READY, 1'b1, "tx_ready");
      fork
         axi_write(uart_pkg::ADDR_TXDATA, {24'd0, b}, wr);
         frame_check(b);
      join
      check_eq("bresp txdata", {30'd0, wr}, {30'd0, uart_pkg::RESP_OKAY});
      wait_status(uart_pkg::STAT_RX_READY, 1'b1, "rx_ready");
      axi_read(uart_pkg::ADDR_RXDATA, d, r);
      check_eq("rxdata", d, {24'd0, b});
      axi_read(uart_pkg::ADDR_STATUS, d, r);
      check_eq("status rx_ready", {31'd0, d[uart_pkg::STAT_RX_READY]}, 32'd0);
      check_eq("rts", {31'd0, rts}, 32'd1); // receiver enabled
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial begin
      logic [31:0] d;
      logic [31:0] rnd;
      logic [1:0]  r;
      logic [1:0]  r2;
      logic [7:0]  b;
      int          i;
      seed      = 32'h8aea;
      rst_int   = 1'b1;
      s_awaddr  = '0;
      s_awvalid = 1'b0;
      s_wdata   = '0;
      s_wstrb   = '0;
      s_wvalid  = 1'b0;
      s_bready  = 1'b0;
      s_araddr  = '0;
      s_arvalid = 1'b0;
      s_rready  = 1'b0;
      cts       = 1'b0;
      repeat (2) @(posedge clk);
      #DRIVE_DLY rst_int = 1'b0;

      // reset values
      check_eq("txd", {31'd0, txd}, 32'd1);
      check_eq("rts", {31'd0, rts}, 32'd0);
      axi_read(uart_pkg::ADDR_CTRL, d, r);
      check_eq("ctrl", d, 32'd0);
      check_eq("rresp ctrl", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});
      axi_read(uart_pkg::ADDR_DIV, d, r);
      check_eq("div", d, {16'd0, uart_pkg::DIV_RESET});
      check_eq("rresp div", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});
      axi_read(uart_pkg::ADDR_STATUS, d, r);
      check_eq("status", d, 32'd0);
      check_eq("rresp status", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});

      // loopback traffic
      cts = 1'b1;
      axi_write(uart_pkg::ADDR_DIV, LOOP_DIV, r);
      check_eq("bresp div", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});
      axi_write(uart_pkg::ADDR_CTRL, 32'h3, r); // tx_en and rx_en
      check_eq("bresp ctrl", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});
      for (i = 0; i < NUM_BYTES; i++) begin
         rnd = $random(seed);
         b   = rnd[7:0];
         send_and_check(b);
      end

      ////////////////////////////////////////
      // error responses
      ////////////////////////////////////////
      axi_read(5'h14, d, r); // unmapped
      check_eq("rresp unmapped", {30'd0, r}, {30'd0, uart_pkg::RESP_SLVERR});
      axi_write(uart_pkg::ADDR_STATUS, 32'h3, r);
      check_eq("bresp status", {30'd0, r}, {30'd0, uart_pkg::RESP_SLVERR});
      wait_status(uart_pkg::STAT_TX_READY, 1'b1, "tx_ready");
      rnd = $random(seed);
      b   = rnd[7:0];
      fork
         begin
            axi_write(uart_pkg::ADDR_TXDATA, {24'd0, b}, r);
            axi_write(uart_pkg::ADDR_TXDATA, {24'd0, ~b}, r2); // transmitter busy
         end
         frame_check(b);
      join
      check_eq("bresp first txdata", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});
      check_eq("bresp busy txdata", {30'd0, r2}, {30'd0, uart_pkg::RESP_SLVERR});
      wait_status(uart_pkg::STAT_RX_READY, 1'b1, "rx_ready");
      axi_read(uart_pkg::ADDR_RXDATA, d, r);
      check_eq("rxdata", d, {24'd0, b});
      for (i = 0; i < 40; i++) begin // longer than a frame, nothing else arrives
         axi_read(uart_pkg::ADDR_STATUS, d, r);
         check_eq("status rx_ready", {31'd0, d[uart_pkg::STAT_RX_READY]}, 32'd0);
      end

      ////////////////////////////////////////
      // flow control and soft reset
      ////////////////////////////////////////
      cts = 1'b0;
      wait_status(uart_pkg::STAT_TX_READY, 1'b0, "tx_ready low");
      axi_write(uart_pkg::ADDR_TXDATA, 32'h5a, r);
      check_eq("bresp txdata no cts", {30'd0, r}, {30'd0, uart_pkg::RESP_SLVERR});
      for (i = 0; i < 4 * LOOP_DIV; i++) begin
         check_eq("txd", {31'd0, txd}, 32'd1);
         next_cycle();
      end
      axi_read(uart_pkg::ADDR_STATUS, d, r);
      check_eq("status tx_ready", {31'd0, d[uart_pkg::STAT_TX_READY]}, 32'd0);

      cts = 1'b1;
      rnd = $random(seed);
      b   = rnd[7:0];
      wait_status(uart_pkg::STAT_TX_READY, 1'b1, "tx_ready");
      fork
         axi_write(uart_pkg::ADDR_TXDATA, {24'd0, b}, r);
         frame_check(b);
      join
      wait_status(uart_pkg::STAT_RX_READY, 1'b1, "rx_ready"); // left unread
      axi_write(uart_pkg::ADDR_CTRL, 32'h7, r); // enables plus soft reset
      check_eq("bresp srst", {30'd0, r}, {30'd0, uart_pkg::RESP_OKAY});
      axi_read(uart_pkg::ADDR_STATUS, d, r);
      check_eq("status after srst", d, 32'd0);
      axi_read(uart_pkg::ADDR_CTRL, d, r);
      check_eq("ctrl after srst", d, 32'h3); // srst bit reads 0
      wait_status(uart_pkg::STAT_TX_READY, 1'b1, "tx_ready after soft reset");

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
verilog/uart_pkg.sv
verilog/uart_ctrl_if.sv
verilog/uart_regs.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
dv/uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
